// File: verilog.f
motion_pkg.sv
dda_axis.sv
move_buffer.sv
move_sequencer.sv
cmd_decoder.sv
motion_top.sv
motion_asserts.sv
tb_motion.sv

// File: tb_motion.sv
// Motion core testbench
module tb_motion;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_CYCLES = 20000;   // Full sequence runs about 2500 cycles

  logic                   CLK;
  logic                   resetn;
  motion_pkg::word_t      word_data_received;
  logic                   word_received;
  motion_pkg::word_t      word_send_data;
  logic                   buffer_dtr;
  logic                   move_done;
  motion_pkg::axis_mask_t step;
  motion_pkg::axis_mask_t dir;
  motion_pkg::axis_mask_t enable;
  motion_pkg::axis_mask_t brake;
  int                     errors = 0;
  int                     cycle = 0;
  int                     done_count = 0;
  int                     done_base;
  int                     t_start;
  integer                 seed = 32'h2628f691;
  motion_pkg::pos_t       exp_pos [motion_pkg::NUM_AXES];
  motion_pkg::word_t      reply;
  motion_pkg::dda_t       inc_a;
  motion_pkg::dda_t       inc_b;
  logic [127:0]           prod;

  motion_top dut_i (
    .CLK(CLK), .resetn(resetn), .word_data_received(word_data_received),
    .word_received(word_received), .word_send_data(word_send_data),
    .buffer_dtr(buffer_dtr), .move_done(move_done), .step(step), .dir(dir),
    .enable(enable), .brake(brake)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(posedge CLK) cycle <= cycle + 1;
  always @(negedge CLK) if (move_done) done_count <= done_count + 1;

  initial begin
    wait (cycle >= MAX_CYCLES);
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Strobe high 2 cycles, low 2 cycles, then take the reply
  task automatic send_word(input motion_pkg::word_t w, output motion_pkg::word_t r);
    word_data_received = w;
    @(posedge CLK);
    #1 word_received = 1'b1;
    repeat (2) @(posedge CLK);
    #1 word_received = 1'b0;
    repeat (2) @(posedge CLK);
    #1 r = word_send_data;
  endtask

  task automatic send_move(input motion_pkg::axis_mask_t mask, input motion_pkg::duration_t dur,
                           input motion_pkg::dda_t inc0, ii0, inc1, ii1);
    motion_pkg::word_t words [6];
    motion_pkg::word_t r;
    words = '{{motion_pkg::CMD_COORDINATED_STEP, 56'(mask)}, 64'(dur), inc0, ii0, inc1, ii1};
    while (!buffer_dtr) begin   // Host back-pressure
      @(posedge CLK);
      #1;
    end
    for (int i = 0; i < 6; i++) begin
      send_word(words[i], r);
      check("move word reply", r, '0);
    end
  endtask

  // Accumulate with the current increment, then add incinc
  function automatic int count_carries(input motion_pkg::duration_t dur,
                                       input motion_pkg::dda_t inc, input motion_pkg::dda_t ii);
    logic [64:0] acc;
    int          n;
    acc = '0;
    n = 0;
    for (int t = 0; t < ((dur == 0) ? 1 : int'(dur)); t++) begin
      acc = {1'b0, acc[63:0]} + {1'b0, inc};
      n += acc[64];
      inc += ii;
    end
    return n;
  endfunction

  task automatic model_move(input motion_pkg::axis_mask_t mask, input motion_pkg::duration_t dur,
                            input motion_pkg::dda_t inc0, ii0, inc1, ii1);
    int n0;
    int n1;
    n0 = count_carries(dur, inc0, ii0);
    n1 = count_carries(dur, inc1, ii1);
    exp_pos[0] = exp_pos[0] + (mask[0] ? n0 : -n0);
    exp_pos[1] = exp_pos[1] + (mask[1] ? n1 : -n1);
  endtask

  task automatic check_positions();
    motion_pkg::word_t r;
    for (int a = 0; a < motion_pkg::NUM_AXES; a++) begin
      send_word({motion_pkg::CMD_READ_POSITION, 8'(a), 48'h0}, r);
      check("read position", r, {32'h0, exp_pos[a]});
    end
  endtask

  task automatic wait_done();
    do @(negedge CLK); while (!move_done);
    @(posedge CLK);
    #1;
  endtask

  // First tick may land anywhere in the divider period
  task automatic check_move_time(input int start, input int div, input int dur);
    int took;
    took = cycle - start;
    if (took < div * (dur - 1) || took > div * (dur + 1)) begin
      errors++;
      $display("[ERROR] %0t: move took %0d cycles, expected %0d to %0d", $time,
               took, div * (dur - 1), div * (dur + 1));
    end
  endtask

  initial begin
    word_data_received = '0;
    word_received = 1'b0;
    resetn = 1'b1;
    exp_pos[0] = '0;
    exp_pos[1] = '0;
    repeat (4) @(posedge CLK);
    #1 resetn = 1'b0;

    // State after reset and channel info
    check("step", step, '0);
    check("move_done", move_done, '0);
    check("enable", enable, '0);
    check("brake", brake, '0);
    check("buffer_dtr", buffer_dtr, 1);
    check_positions();
    send_word({motion_pkg::CMD_CHANNEL_INFO, 56'h0}, reply);
    check("channel info", reply, {40'h0, 8'(motion_pkg::POS_BITS), 8'(motion_pkg::DDA_BITS),
                                  8'(motion_pkg::NUM_AXES)});

    // Configuration bits and echo of an unknown code
    send_word({motion_pkg::CMD_MOTOR_ENABLE, 56'h2}, reply);
    check("enable", enable, 2'b10);
    send_word({motion_pkg::CMD_MOTOR_BRAKE, 56'h1}, reply);
    check("brake", brake, 2'b01);
    send_word({8'h77, 24'h123456, $random(seed)}, reply);
    check("echo", reply, word_data_received);

    // Constant velocity, position is floor(duration * increment / 2^64)
    inc_a = {$random(seed), $random(seed)};
    inc_b = {$random(seed), $random(seed)};
    send_move(2'b01, 20, inc_a, '0, inc_b, '0);
    t_start = cycle;
    check("dir", dir, 2'b01);
    wait_done();
    check_move_time(t_start, motion_pkg::DEFAULT_DIVISOR, 20);   // Divisor after reset
    prod = 128'(inc_a) * 20;
    exp_pos[0] = motion_pkg::pos_t'(prod[95:64]);
    prod = 128'(inc_b) * 20;
    exp_pos[1] = -motion_pkg::pos_t'(prod[95:64]);
    check_positions();

    // Accelerating and decelerating axes
    send_move(2'b10, 16, 64'h0800_0000_0000_0000, 64'h0100_0000_0000_0000,
              64'h9000_0000_0000_0000, 64'hfc00_0000_0000_0000);
    check("dir", dir, 2'b10);
    wait_done();
    model_move(2'b10, 16, 64'h0800_0000_0000_0000, 64'h0100_0000_0000_0000,
               64'h9000_0000_0000_0000, 64'hfc00_0000_0000_0000);
    check_positions();

    // Two moves queued, the second one fills the buffer
    done_base = done_count;
    send_move(2'b11, 10, inc_b, '0, 64'h6000_0000_0000_0000, '0);
    send_move(2'b00, 12, 64'hc000_0000_0000_0000, '0, inc_a, 64'h0010_0000_0000_0000);
    check("buffer_dtr when full", buffer_dtr, 0);
    check("dir of running move", dir, 2'b11);
    model_move(2'b11, 10, inc_b, '0, 64'h6000_0000_0000_0000, '0);
    model_move(2'b00, 12, 64'hc000_0000_0000_0000, '0, inc_a, 64'h0010_0000_0000_0000);
    wait_done();
    wait_done();
    repeat (4) @(posedge CLK);
    #1 check("move_done count", done_count - done_base, 2);
    check("buffer_dtr", buffer_dtr, 1);
    check_positions();

    // Faster ticks
    send_word({motion_pkg::CMD_CLK_DIVISOR, 56'd8}, reply);
    check("divisor reply", reply, '0);
    send_move(2'b01, 30, 64'h4000_0000_0000_0000, '0, 64'h2000_0000_0000_0000, '0);
    t_start = cycle;
    wait_done();
    check_move_time(t_start, 8, 30);
    model_move(2'b01, 30, 64'h4000_0000_0000_0000, '0, 64'h2000_0000_0000_0000, '0);
    check_positions();

    repeat (4) @(posedge CLK);
    $display("Value errors: %0d, assertion failures: %0d", errors, dut_i.asserts_i.fail_count);
    if (errors == 0 && dut_i.asserts_i.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: motion_asserts.sv
// Motion core assertions
module motion_asserts (
  input logic                               CLK,
  input logic                               resetn,
  input motion_pkg::axis_mask_t             step,
  input logic                               move_done,
  input logic                               buffer_dtr,
  input logic                               executing,
  input logic [motion_pkg::BUFFER_SIZE-1:0] slot_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;   // Read by the testbench at the end

  for (genvar a = 0; a < motion_pkg::NUM_AXES; a++) begin : g_step
    step_pulse: assert property (@(posedge CLK) disable iff (resetn) step[a] |=> !step[a])
      else begin
        $error("step on axis %0d lasted more than one cycle", a);
        fail_count++;
      end
  end

  done_pulse: assert property (@(posedge CLK) disable iff (resetn) move_done |=> !move_done)
    else begin
      $error("move_done lasted more than one cycle");
      fail_count++;
    end

  // Step is registered one cycle after the carry
  step_in_move: assert property (@(posedge CLK) disable iff (resetn)
    (step != '0) |-> $past(executing))
    else begin
      $error("step pulse outside a move");
      fail_count++;
    end

  // In a two-slot ring a busy write slot means both are busy
  dtr_full: assert property (@(posedge CLK) disable iff (resetn) !buffer_dtr |-> &slot_ready)
    else begin
      $error("buffer_dtr low while a slot is free");
      fail_count++;
    end

endmodule

bind motion_top motion_asserts asserts_i (
  .CLK(CLK), .resetn(resetn), .step(step), .move_done(move_done),
  .buffer_dtr(buffer_dtr), .executing(executing), .slot_ready(slot_ready)
);

// File: motion_top.sv
// Stepper motion core top level
module motion_top (
  input  logic                   CLK,
  input  logic                   resetn,
  input  motion_pkg::word_t      word_data_received,
  input  logic                   word_received,
  output motion_pkg::word_t      word_send_data,
  output logic                   buffer_dtr,
  output logic                   move_done,
  output motion_pkg::axis_mask_t step,
  output motion_pkg::axis_mask_t dir,
  output motion_pkg::axis_mask_t enable,
  output motion_pkg::axis_mask_t brake
);

  motion_pkg::axis_mask_t            wr_dir;
  motion_pkg::duration_t             wr_duration;
  motion_pkg::dda_t                  wr_increment [motion_pkg::NUM_AXES];
  motion_pkg::dda_t                  wr_incinc [motion_pkg::NUM_AXES];
  logic                              commit;
  logic [motion_pkg::BUFFER_SIZE-1:0] slot_ready;
  motion_pkg::slot_t                 rd_slot;
  logic                              retire;
  motion_pkg::duration_t             rd_duration;
  motion_pkg::dda_t                  rd_increment [motion_pkg::NUM_AXES];
  motion_pkg::dda_t                  rd_incinc [motion_pkg::NUM_AXES];
  motion_pkg::divisor_t              clock_divisor;
  logic                              dda_tick;
  logic                              load_move;
  logic                              executing;
  motion_pkg::pos_t                  position [motion_pkg::NUM_AXES];

  cmd_decoder decoder_i (
    .CLK(CLK), .resetn(resetn),
    .word_data_received(word_data_received), .word_received(word_received),
    .word_send_data(word_send_data), .enable(enable), .brake(brake),
    .clock_divisor(clock_divisor), .position(position),
    .wr_dir(wr_dir), .wr_duration(wr_duration), .wr_increment(wr_increment),
    .wr_incinc(wr_incinc), .commit(commit)
  );

  // Direction of the running slot goes straight to the pins
  move_buffer buffer_i (
    .CLK(CLK), .resetn(resetn),
    .wr_dir(wr_dir), .wr_duration(wr_duration), .wr_increment(wr_increment),
    .wr_incinc(wr_incinc), .commit(commit), .rd_slot(rd_slot), .retire(retire),
    .slot_ready(slot_ready), .buffer_dtr(buffer_dtr), .rd_dir(dir),
    .rd_duration(rd_duration), .rd_increment(rd_increment), .rd_incinc(rd_incinc)
  );

  move_sequencer sequencer_i (
    .CLK(CLK), .resetn(resetn),
    .clock_divisor(clock_divisor), .slot_ready(slot_ready), .rd_duration(rd_duration),
    .rd_slot(rd_slot), .retire(retire), .dda_tick(dda_tick), .load_move(load_move),
    .executing(executing), .move_done(move_done)
  );

  for (genvar a = 0; a < motion_pkg::NUM_AXES; a++) begin : g_axis
    dda_axis axis_i (
      .CLK(CLK), .resetn(resetn),
      .dda_tick(dda_tick), .load_move(load_move), .executing(executing),
      .increment(rd_increment[a]), .incinc(rd_incinc[a]), .dir(dir[a]),
      .step(step[a]), .position(position[a])
    );
  end

endmodule

// File: cmd_decoder.sv
// Host command decoder
module cmd_decoder (
  input  logic                   CLK,
  input  logic                   resetn,
  input  motion_pkg::word_t      word_data_received,
  input  logic                   word_received,
  output motion_pkg::word_t      word_send_data,
  output motion_pkg::axis_mask_t enable,
  output motion_pkg::axis_mask_t brake,
  output motion_pkg::divisor_t   clock_divisor,
  input  motion_pkg::pos_t       position [motion_pkg::NUM_AXES],
  output motion_pkg::axis_mask_t wr_dir,
  output motion_pkg::duration_t  wr_duration,
  output motion_pkg::dda_t       wr_increment [motion_pkg::NUM_AXES],
  output motion_pkg::dda_t       wr_incinc [motion_pkg::NUM_AXES],
  output logic                   commit
);

  logic                  strobe_q;     // Registered strobe
  logic                  strobe_qq;
  logic                  word_rise;
  motion_pkg::cmd_t      code;         // Code field of the incoming word
  motion_pkg::cmd_t      msg_header;   // Header of the message in progress
  logic [7:0]            msg_count;    // Move words taken, header is 1
  logic                  in_move;
  logic                  last_word;
  motion_pkg::pos_t      sel_position;

  assign word_rise = strobe_q & ~strobe_qq;
  assign code      = word_data_received[motion_pkg::WORD_BITS-1 -: 8];
  assign in_move   = (msg_header == motion_pkg::CMD_COORDINATED_STEP);

  // Final incinc word of the last axis
  assign last_word = (msg_count == 8'(2 * motion_pkg::NUM_AXES + 1));

  // Axis named by bits 55 to 48 for position reads
  always_comb begin
    sel_position = '0;
    for (int a = 0; a < motion_pkg::NUM_AXES; a++) begin
      if (word_data_received[55:48] == 8'(a)) begin
        sel_position = position[a];
      end
    end
  end

  // Strobe edge detect
  always_ff @(posedge CLK) begin
    if (resetn) begin
      strobe_q  <= 1'b0;
      strobe_qq <= 1'b0;
    end else begin
      strobe_q  <= word_received;
      strobe_qq <= strobe_q;
    end
  end

  // Message tracking, configuration and replies
  always_ff @(posedge CLK) begin
    if (resetn) begin
      msg_header     <= '0;
      msg_count      <= '0;
      commit         <= 1'b0;
      word_send_data <= '0;
      enable         <= '0;
      brake          <= '0;
      clock_divisor  <= motion_pkg::divisor_t'(motion_pkg::DEFAULT_DIVISOR);
    end else begin
      commit <= 1'b0;
      if (word_rise) begin
        if (in_move) begin
          word_send_data <= '0;   // Move words answer zero
          msg_count      <= msg_count + 8'd1;
          if (last_word) begin
            msg_header <= '0;
            commit     <= 1'b1;
          end
        end else begin
          msg_header <= code;
          msg_count  <= 8'd1;
          case (code)
            motion_pkg::CMD_COORDINATED_STEP: begin
              word_send_data <= '0;
            end
            motion_pkg::CMD_READ_POSITION: begin
              word_send_data <= '0;
              word_send_data[motion_pkg::POS_BITS-1:0] <= sel_position;
            end
            motion_pkg::CMD_MOTOR_ENABLE: begin
              enable         <= word_data_received[motion_pkg::NUM_AXES-1:0];
              word_send_data <= '0;
            end
            motion_pkg::CMD_MOTOR_BRAKE: begin
              brake          <= word_data_received[motion_pkg::NUM_AXES-1:0];
              word_send_data <= '0;
            end
            motion_pkg::CMD_CLK_DIVISOR: begin
              clock_divisor  <= word_data_received[motion_pkg::DIVISOR_BITS-1:0];
              word_send_data <= '0;
            end
            motion_pkg::CMD_CHANNEL_INFO: begin
              word_send_data        <= '0;
              word_send_data[7:0]   <= 8'(motion_pkg::NUM_AXES);
              word_send_data[15:8]  <= 8'(motion_pkg::DDA_BITS);
              word_send_data[23:16] <= 8'(motion_pkg::POS_BITS);
            end
            default: word_send_data <= word_data_received;   // Unknown, echo back
          endcase
        end
      end
    end
  end

  // Move staging registers feeding the buffer
  always_ff @(posedge CLK) begin
    if (word_rise) begin
      if (!in_move && code == motion_pkg::CMD_COORDINATED_STEP) begin
        wr_dir <= word_data_received[motion_pkg::NUM_AXES-1:0];
      end
      if (in_move && msg_count == 8'd1) begin
        wr_duration <= word_data_received[motion_pkg::DURATION_BITS-1:0];
      end
      // Increment then incinc for each axis in turn
      for (int a = 0; a < motion_pkg::NUM_AXES; a++) begin
        if (in_move && msg_count == 8'(2 + 2 * a)) begin
          wr_increment[a] <= motion_pkg::dda_t'(word_data_received);
        end
        if (in_move && msg_count == 8'(3 + 2 * a)) begin
          wr_incinc[a] <= motion_pkg::dda_t'(word_data_received);
        end
      end
    end
  end

endmodule

// File: move_sequencer.sv
// Move sequencer with tick divider
module move_sequencer (
  input  logic                              CLK,
  input  logic                              resetn,
  input  motion_pkg::divisor_t              clock_divisor,
  input  logic [motion_pkg::BUFFER_SIZE-1:0] slot_ready,
  input  motion_pkg::duration_t             rd_duration,
  output motion_pkg::slot_t                 rd_slot,
  output logic                              retire,
  output logic                              dda_tick,
  output logic                              load_move,
  output logic                              executing,
  output logic                              move_done
);

  motion_pkg::divisor_t   div_cnt;      // Free-running divider count
  motion_pkg::duration_t  tick_count;   // Ticks seen in the current move
  motion_pkg::seq_state_t state;
  logic                   last_tick;

  assign load_move = (state == motion_pkg::LOAD);
  assign executing = (state == motion_pkg::RUN);

  // Duration 0 still takes one tick
  assign last_tick = executing & dda_tick & ((tick_count + 1'b1) >= rd_duration);

  assign move_done = last_tick;
  assign retire    = last_tick;   // Slot freed while rd_slot still points at it

  // One-cycle tick every clock_divisor cycles
  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_cnt  <= '0;
      dda_tick <= 1'b0;
    end else if ((div_cnt + 1'b1) >= clock_divisor) begin
      div_cnt  <= '0;
      dda_tick <= 1'b1;
    end else begin
      div_cnt  <= div_cnt + 1'b1;
      dda_tick <= 1'b0;
    end
  end

  // Slot FSM
  always_ff @(posedge CLK) begin
    if (resetn) begin
      state      <= motion_pkg::IDLE;
      rd_slot    <= '0;
      tick_count <= '0;
    end else begin
      case (state)
        motion_pkg::IDLE: begin
          if (slot_ready[rd_slot]) begin
            state <= motion_pkg::LOAD;
          end
        end
        motion_pkg::LOAD: begin
          tick_count <= '0;
          state      <= motion_pkg::RUN;
        end
        motion_pkg::RUN: begin
          if (dda_tick) begin
            tick_count <= tick_count + 1'b1;
          end
          if (last_tick) begin
            rd_slot <= rd_slot + 1'b1;   // Next slot in order
            state   <= motion_pkg::IDLE;
          end
        end
        default: state <= motion_pkg::IDLE;
      endcase
    end
  end

endmodule

// File: move_buffer.sv
// Two-slot move buffer
module move_buffer (
  input  logic                              CLK,
  input  logic                              resetn,
  input  motion_pkg::axis_mask_t            wr_dir,
  input  motion_pkg::duration_t             wr_duration,
  input  motion_pkg::dda_t                  wr_increment [motion_pkg::NUM_AXES],
  input  motion_pkg::dda_t                  wr_incinc [motion_pkg::NUM_AXES],
  input  logic                              commit,
  input  motion_pkg::slot_t                 rd_slot,
  input  logic                              retire,
  output logic [motion_pkg::BUFFER_SIZE-1:0] slot_ready,
  output logic                              buffer_dtr,
  output motion_pkg::axis_mask_t            rd_dir,
  output motion_pkg::duration_t             rd_duration,
  output motion_pkg::dda_t                  rd_increment [motion_pkg::NUM_AXES],
  output motion_pkg::dda_t                  rd_incinc [motion_pkg::NUM_AXES]
);

  motion_pkg::axis_mask_t dir_mem [motion_pkg::BUFFER_SIZE];
  motion_pkg::duration_t  dur_mem [motion_pkg::BUFFER_SIZE];
  motion_pkg::dda_t       inc_mem [motion_pkg::BUFFER_SIZE][motion_pkg::NUM_AXES];
  motion_pkg::dda_t       incinc_mem [motion_pkg::BUFFER_SIZE][motion_pkg::NUM_AXES];
  motion_pkg::slot_t      wr_idx;   // Next slot to fill
  logic                   accept;

  // Commit into an occupied slot is ignored
  assign accept     = commit & ~slot_ready[wr_idx];
  assign buffer_dtr = ~slot_ready[wr_idx];

  // Ready flags and write index
  always_ff @(posedge CLK) begin
    if (resetn) begin
      slot_ready <= '0;
      wr_idx     <= '0;
    end else begin
      if (retire) begin
        slot_ready[rd_slot] <= 1'b0;
      end
      if (accept) begin
        slot_ready[wr_idx] <= 1'b1;
        wr_idx             <= wr_idx + 1'b1;   // Wraps over the slots
      end
    end
  end

  // Move records
  always_ff @(posedge CLK) begin
    if (accept) begin
      dir_mem[wr_idx] <= wr_dir;
      dur_mem[wr_idx] <= wr_duration;
      for (int a = 0; a < motion_pkg::NUM_AXES; a++) begin
        inc_mem[wr_idx][a]    <= wr_increment[a];
        incinc_mem[wr_idx][a] <= wr_incinc[a];
      end
    end
  end

  // Read port follows the sequencer's slot
  always_comb begin
    rd_dir      = dir_mem[rd_slot];
    rd_duration = dur_mem[rd_slot];
    for (int a = 0; a < motion_pkg::NUM_AXES; a++) begin
      rd_increment[a] = inc_mem[rd_slot][a];
      rd_incinc[a]    = incinc_mem[rd_slot][a];
    end
  end

endmodule

// File: dda_axis.sv
// Per-axis DDA step generator
module dda_axis (
  input  logic             CLK,
  input  logic             resetn,
  input  logic             dda_tick,
  input  logic             load_move,
  input  logic             executing,
  input  motion_pkg::dda_t increment,
  input  motion_pkg::dda_t incinc,
  input  logic             dir,
  output logic             step,
  output motion_pkg::pos_t position
);

  motion_pkg::dda_t              accum;     // Phase accumulator
  motion_pkg::dda_t              inc_run;   // Increment, grows by incinc each tick
  logic [motion_pkg::DDA_BITS:0] sum;       // Top bit is the carry
  logic                          advance;
  logic                          carry;

  assign advance = executing & dda_tick;
  assign sum     = {1'b0, accum} + {1'b0, inc_run};
  assign carry   = advance & sum[motion_pkg::DDA_BITS];

  // Accumulate with the old increment, then bump the increment
  always_ff @(posedge CLK) begin
    if (load_move) begin
      accum   <= '0;
      inc_run <= increment;
    end else if (advance) begin
      accum   <= sum[motion_pkg::DDA_BITS-1:0];
      inc_run <= inc_run + incinc;
    end
  end

  // One step per carry
  always_ff @(posedge CLK) begin
    if (resetn) begin
      step     <= 1'b0;
      position <= '0;
    end else begin
      step <= carry;
      if (carry) begin
        // dir 1 counts up, dir 0 counts down
        if (dir) begin
          position <= position + motion_pkg::pos_t'(1);
        end else begin
          position <= position - motion_pkg::pos_t'(1);
        end
      end
    end
  end

endmodule

// File: motion_pkg.sv
// Motion core shared definitions
package motion_pkg;

  // Axis and datapath sizes
  localparam int NUM_AXES      = 2;
  localparam int WORD_BITS     = 64;   // Host command word
  localparam int DDA_BITS      = 64;   // Accumulator and increments
  localparam int DURATION_BITS = 32;   // Move length in ticks
  localparam int POS_BITS      = 32;   // Signed step position

  // Move buffer
  localparam int BUFFER_SIZE = 2;
  localparam int SLOT_BITS   = 1;

  // Step tick divider
  localparam int DIVISOR_BITS    = 8;
  localparam int DEFAULT_DIVISOR = 32;

  // Vector types
  typedef logic [WORD_BITS-1:0] word_t;

  typedef logic [DDA_BITS-1:0] dda_t;

  typedef logic [DURATION_BITS-1:0] duration_t;

  // Steps taken since reset, may go negative
  typedef logic signed [POS_BITS-1:0] pos_t;

  typedef logic [NUM_AXES-1:0] axis_mask_t;   // One bit per axis

  typedef logic [SLOT_BITS-1:0] slot_t;

  typedef logic [DIVISOR_BITS-1:0] divisor_t;

  typedef logic [7:0] cmd_t;   // Header code, word bits 63 to 56

  // Command codes
  localparam cmd_t CMD_COORDINATED_STEP = 8'h01;   // Multi-word move message
  localparam cmd_t CMD_READ_POSITION    = 8'h03;
  localparam cmd_t CMD_MOTOR_ENABLE     = 8'h0a;
  localparam cmd_t CMD_MOTOR_BRAKE      = 8'h0b;
  localparam cmd_t CMD_CLK_DIVISOR      = 8'h20;
  localparam cmd_t CMD_CHANNEL_INFO     = 8'hfd;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE,   // Waiting for a ready slot
    LOAD,   // Clear accumulators, latch increments
    RUN     // Counting ticks
  } seq_state_t;

endpackage
